//--- source/lc_defs.svh
// link controller counter widths
// protocol time constants for the slave page response

`ifndef LC_DEFS_SVH
`define LC_DEFS_SVH

//////////////////////////////
// counter widths
//////////////////////////////

// microsecond counters
`define LC_US_W 11
// slot counts, scan interval and window
`define LC_SLOT_W 16

//////////////////////////////
// protocol timing
//////////////////////////////

// half slot after the ID transmit starts, in us
`define LC_HALF_SLOT_US 312
// slots to wait for the master FHS
`define LC_PAGE_RESP_TO_SLOTS 8
// slots to wait for the first addressed poll
`define LC_NEW_CONN_TO_SLOTS 16

`endif

//--- source/lc_state_pkg.sv
// link controller state encoding

`default_nettype none

package lc_state_pkg;

  // slave side states only
  // page scan, slave page response, new connection, active
  typedef enum logic [3:0] {
    st_standby          = 4'd0,
    st_page_scan        = 4'd1,
    // send ID back to master
    st_slave_txid       = 4'd2,
    // wait for master FHS
    st_slave_rxfhs      = 4'd3,
    // FHS received, wait slot boundary
    st_slave_rxfhs_done = 4'd4,
    // send ID as FHS ack
    st_slave_ackfhs     = 4'd5,
    // wait first poll from master
    st_conn_new_slave   = 4'd6,
    // reply to the poll
    st_conn_ackpoll     = 4'd7,
    st_conn_active      = 4'd8
  } lc_state_t;

endpackage

`default_nettype wire

//--- source/lc_time_pkg.sv
// vector types for microsecond and slot counts

`default_nettype none

`include "lc_defs.svh"

package lc_time_pkg;

  // us count, half slot delay
  typedef logic [`LC_US_W-1:0] us_count_t;

  // slot count
  // also the page scan interval and window registers
  typedef logic [`LC_SLOT_W-1:0] slot_count_t;

endpackage

`default_nettype wire

//--- source/lc_timer_if.sv
// state machine to slave timer link
// fsm_mp and timer_mp modports

`timescale 1ns/1ps
`default_nettype none

interface lc_timer_if
  import lc_state_pkg::*;
(
  // timing strobes from the top level
  input wire logic p_1us,
  input wire logic s_tslot_p
);

  // current link controller state
  lc_state_t state;

  // timer end pulses
  logic half_slot_endp;
  logic resp_to;
  logic new_conn_to;

  // state machine side
  modport fsm_mp (
    output state,
    input  p_1us, s_tslot_p, half_slot_endp, resp_to, new_conn_to
  );

  // timer side
  modport timer_mp (
    output half_slot_endp, resp_to, new_conn_to,
    input  state, p_1us, s_tslot_p
  );

endinterface

`default_nettype wire

//--- source/page_scan_window.sv
// page scan enable latch
// interval / window slot timer and scan window level

`timescale 1ns/1ps
`default_nettype none

module page_scan_window
  import lc_time_pkg::*;
(
  input  wire logic        clk_6M,
  input  wire logic        rstz,
  // slave slot boundary
  input  wire logic        s_tslot_p,
  // host one-shots
  input  wire logic        page_scan_enable_p,
  input  wire logic        page_scan_cancel_p,
  // connection set up, stop scanning
  input  wire logic        ps_done_p,
  // scan interval and window in slots
  input  wire slot_count_t t_ps_interval,
  input  wire slot_count_t t_ps_window,
  output logic             window
);

  logic        scan_en;
  slot_count_t slot_cnt;
  logic        last_slot;

  //////////////////////////////
  // enable latch
  //////////////////////////////

  // clear beats set when both arrive together
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      scan_en <= 1'b0;
    else if (page_scan_cancel_p || ps_done_p)
      scan_en <= 1'b0;
    else if (page_scan_enable_p)
      scan_en <= 1'b1;
  end

  //////////////////////////////
  // interval slot counter
  //////////////////////////////

  // final slot of the interval
  assign last_slot = (slot_cnt == slot_count_t'(t_ps_interval - 1'b1));

  // enable pulse restarts the interval
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      slot_cnt <= '0;
    else if (page_scan_enable_p)
      slot_cnt <= '0;
    else if (scan_en && s_tslot_p)
    begin
      if (last_slot)
        slot_cnt <= '0;
      else
        slot_cnt <= slot_cnt + 1'b1;
    end
  end

  // window open at the start of every interval
  assign window = scan_en && (slot_cnt < t_ps_window);

endmodule

`default_nettype wire

//--- source/slave_resp_timers.sv
// slave response timers
// half slot delay, page response timeout, new connection timeout

`timescale 1ns/1ps
`default_nettype none

`include "lc_defs.svh"

module slave_resp_timers
  import lc_state_pkg::*;
  import lc_time_pkg::*;
(
  input  wire logic clk_6M,
  input  wire logic rstz,
  lc_timer_if.timer_mp tmr
);

  us_count_t   half_us_cnt;
  slot_count_t resp_slot_cnt;
  slot_count_t conn_slot_cnt;

  logic in_txid;
  logic in_rxfhs;
  logic in_new_slave;

  // each counter lives only in its own state
  assign in_txid      = (tmr.state == st_slave_txid);
  assign in_rxfhs     = (tmr.state == st_slave_rxfhs);
  assign in_new_slave = (tmr.state == st_conn_new_slave);

  //////////////////////////////
  // half slot delay
  //////////////////////////////

  // us since ID transmit start
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      half_us_cnt <= '0;
    else if (!in_txid)
      half_us_cnt <= '0;
    else if (tmr.p_1us)
      half_us_cnt <= half_us_cnt + 1'b1;
  end

  // 312th us strobe in txid
  assign tmr.half_slot_endp = in_txid && tmr.p_1us &&
    (half_us_cnt == us_count_t'(`LC_HALF_SLOT_US - 1));

  //////////////////////////////
  // page response timeout
  //////////////////////////////

  // slots spent waiting for FHS
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      resp_slot_cnt <= '0;
    else if (!in_rxfhs)
      resp_slot_cnt <= '0;
    else if (tmr.s_tslot_p)
      resp_slot_cnt <= resp_slot_cnt + 1'b1;
  end

  // 8th slot pulse without FHS
  assign tmr.resp_to = in_rxfhs && tmr.s_tslot_p &&
    (resp_slot_cnt == slot_count_t'(`LC_PAGE_RESP_TO_SLOTS - 1));

  //////////////////////////////
  // new connection timeout
  //////////////////////////////

  // slots spent waiting for the first poll
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      conn_slot_cnt <= '0;
    else if (!in_new_slave)
      conn_slot_cnt <= '0;
    else if (tmr.s_tslot_p)
      conn_slot_cnt <= conn_slot_cnt + 1'b1;
  end

  // 16th slot pulse, no poll from master
  assign tmr.new_conn_to = in_new_slave && tmr.s_tslot_p &&
    (conn_slot_cnt == slot_count_t'(`LC_NEW_CONN_TO_SLOTS - 1));

endmodule

`default_nettype wire

//--- source/lc_fsm.sv
// link controller state machine with return state
// state decodes, transmit start and first slot flag

`timescale 1ns/1ps
`default_nettype none

module lc_fsm
  import lc_state_pkg::*;
(
  input  wire logic    clk_6M,
  input  wire logic    rstz,
  lc_timer_if.fsm_mp   tmr,
  // page scan window level
  input  wire logic    window,
  // access code match from the correlator
  input  wire logic    corre_hit,
  // FHS with good HEC and CRC
  input  wire logic    fhs_ok,
  // current rx packet is a poll to us
  input  wire logic    poll_addressed,
  // host transmit command
  input  wire logic    tx_cmd_p,
  output logic         ps_done_p,
  output logic         ps,
  output logic         spr,
  output logic         conns,
  output logic         pstxid,
  output logic         psrxfhs,
  output logic         psackfhs,
  output logic         connsnewslave,
  output logic         ps_pagerespto,
  output logic         tx_packet_st_p,
  output logic         tx_first_slot
);

  lc_state_t cs;
  lc_state_t ns;
  lc_state_t ret_q;
  lc_state_t ret_d;

  logic ps_hit_p;
  logic poll_acc_p;
  logic conn_tx_p;
  logic tx_pend;

  //////////////////////////////
  // state registers
  //////////////////////////////

  // updated every clock, no 1us gating
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      cs    <= st_standby;
      ret_q <= st_standby;
    end
    else
    begin
      cs    <= ns;
      ret_q <= ret_d;
    end
  end

  assign tmr.state = cs;

  //////////////////////////////
  // next state
  //////////////////////////////

  always_comb
  begin
    ns    = cs;
    ret_d = ret_q;
    case (cs)
      st_standby, st_conn_active:
      begin
        // remember where to come back to
        if (window)
        begin
          ns    = st_page_scan;
          ret_d = cs;
        end
      end
      st_page_scan:
      begin
        // window test before the hit
        if (!window)
          ns = ret_q;
        else if (corre_hit)
          ns = st_slave_txid;
      end
      st_slave_txid:
        if (tmr.half_slot_endp)
          ns = st_slave_rxfhs;
      st_slave_rxfhs:
      begin
        // timeout wins over a late FHS
        if (tmr.resp_to)
          ns = st_page_scan;
        else if (fhs_ok)
          ns = st_slave_rxfhs_done;
      end
      st_slave_rxfhs_done:
        if (tmr.s_tslot_p)
          ns = st_slave_ackfhs;
      st_slave_ackfhs:
        if (tmr.s_tslot_p)
          ns = st_conn_new_slave;
      st_conn_new_slave:
      begin
        if (poll_acc_p)
          ns = st_conn_ackpoll;
        else if (tmr.new_conn_to)
          ns = st_standby;
      end
      st_conn_ackpoll:
        if (tmr.s_tslot_p)
          ns = st_conn_active;
      default:
        ns = st_standby;
    endcase
  end

  //////////////////////////////
  // event pulses
  //////////////////////////////

  // ack sent, scanning is over
  assign ps_done_p  = (cs == st_slave_ackfhs) && tmr.s_tslot_p;
  // sync hit while scanning
  assign ps_hit_p   = (cs == st_page_scan) && window && corre_hit;
  // addressed poll at the slot boundary
  assign poll_acc_p = (cs == st_conn_new_slave) && poll_addressed && tmr.s_tslot_p;
  // pending host packet at the next slave slot
  assign conn_tx_p  = (cs == st_conn_active) && tmr.s_tslot_p && tx_pend;

  assign ps_pagerespto = (cs == st_slave_rxfhs) && tmr.resp_to;

  // ID reply, FHS ack, poll reply, host data
  assign tx_packet_st_p = ps_hit_p ||
                          ((cs == st_slave_rxfhs_done) && tmr.s_tslot_p) ||
                          poll_acc_p ||
                          conn_tx_p;

  //////////////////////////////
  // transmit command and first slot
  //////////////////////////////

  // a new command keeps the request alive
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      tx_pend <= 1'b0;
    else if (tx_cmd_p)
      tx_pend <= 1'b1;
    else if (conn_tx_p)
      tx_pend <= 1'b0;
  end

  // high through the slot a packet starts in
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      tx_first_slot <= 1'b0;
    else if (tx_packet_st_p)
      tx_first_slot <= 1'b1;
    else if (tmr.s_tslot_p)
      tx_first_slot <= 1'b0;
  end

  //////////////////////////////
  // state decodes
  //////////////////////////////

  assign ps       = (cs == st_page_scan);
  assign pstxid   = (cs == st_slave_txid);
  assign psackfhs = (cs == st_slave_ackfhs);
  assign psrxfhs  = (cs == st_slave_rxfhs) || (cs == st_slave_rxfhs_done);
  // whole slave page response
  assign spr      = pstxid || psrxfhs || psackfhs;
  assign connsnewslave = (cs == st_conn_new_slave) || (cs == st_conn_ackpoll);
  assign conns    = connsnewslave || (cs == st_conn_active);

endmodule

`default_nettype wire

//--- source/link_ctrl_top.sv
// slave link controller top level
// page scan window, response timers and state machine

`timescale 1ns/1ps
`default_nettype none

module link_ctrl_top
  import lc_time_pkg::*;
(
  input  wire logic        clk_6M,
  input  wire logic        rstz,
  // timing strobes
  input  wire logic        p_1us,
  input  wire logic        s_tslot_p,
  // host page scan control
  input  wire logic        page_scan_enable_p,
  input  wire logic        page_scan_cancel_p,
  input  wire slot_count_t t_ps_interval,
  input  wire slot_count_t t_ps_window,
  // receive side events
  input  wire logic        corre_hit,
  input  wire logic        fhs_ok,
  input  wire logic        poll_addressed,
  input  wire logic        tx_cmd_p,
  // state levels
  output logic             ps,
  output logic             spr,
  output logic             conns,
  output logic             pstxid,
  output logic             psrxfhs,
  output logic             psackfhs,
  output logic             connsnewslave,
  output logic             page_scan_window,
  output logic             ps_pagerespto,
  output logic             tx_packet_st_p,
  output logic             tx_first_slot
);

  // connection made, drop scan enable
  logic ps_done_p;

  // timer link, strobes come straight from the ports
  lc_timer_if tmr (
    .p_1us     (p_1us),
    .s_tslot_p (s_tslot_p)
  );

  page_scan_window page_scan_window_i (
    .clk_6M             (clk_6M),
    .rstz               (rstz),
    .s_tslot_p          (s_tslot_p),
    .page_scan_enable_p (page_scan_enable_p),
    .page_scan_cancel_p (page_scan_cancel_p),
    .ps_done_p          (ps_done_p),
    .t_ps_interval      (t_ps_interval),
    .t_ps_window        (t_ps_window),
    .window             (page_scan_window)
  );

  slave_resp_timers slave_resp_timers_i (
    .clk_6M (clk_6M),
    .rstz   (rstz),
    .tmr    (tmr.timer_mp)
  );

  lc_fsm lc_fsm_i (
    .clk_6M         (clk_6M),
    .rstz           (rstz),
    .tmr            (tmr.fsm_mp),
    .window         (page_scan_window),
    .corre_hit      (corre_hit),
    .fhs_ok         (fhs_ok),
    .poll_addressed (poll_addressed),
    .tx_cmd_p       (tx_cmd_p),
    .ps_done_p      (ps_done_p),
    .ps             (ps),
    .spr            (spr),
    .conns          (conns),
    .pstxid         (pstxid),
    .psrxfhs        (psrxfhs),
    .psackfhs       (psackfhs),
    .connsnewslave  (connsnewslave),
    .ps_pagerespto  (ps_pagerespto),
    .tx_packet_st_p (tx_packet_st_p),
    .tx_first_slot  (tx_first_slot)
  );

endmodule

`default_nettype wire

//--- test/lc_clk_gen.sv
// testbench clock and reset source
// 10 ns clock, reset held low for two cycles

`timescale 1ns/1ps
`default_nettype none

module lc_clk_gen
(
  output logic clk_6M,
  output logic rstz
);

  // free running clock
  initial
  begin
    clk_6M = 1'b0;
    forever #5 clk_6M = ~clk_6M;
  end

  // release between the stimulus step and the sample point
  initial
  begin
    rstz = 1'b0;
    repeat (2) @(posedge clk_6M);
    #2;
    rstz = 1'b1;
  end

endmodule

`default_nettype wire

//--- test/tb_link_ctrl.sv
// link controller testbench
// random page scan, page response and connection stimulus
// cycle model of the controller compared on all outputs each cycle

`timescale 1ns/1ps
`default_nettype none

module tb_link_ctrl
  import lc_state_pkg::*;
  import lc_time_pkg::*;
();

  // timing from the radio standard
  localparam int slot_cycles   = 3750;
  localparam int half_slot_us  = 312;
  localparam int resp_to_slots = 8;
  localparam int conn_to_slots = 16;

  logic        clk_6M;
  logic        rstz;
  logic        p_1us;
  logic        s_tslot_p;
  logic        page_scan_enable_p;
  logic        page_scan_cancel_p;
  slot_count_t t_ps_interval;
  slot_count_t t_ps_window;
  logic        corre_hit;
  logic        fhs_ok;
  logic        poll_addressed;
  logic        tx_cmd_p;
  logic        ps;
  logic        spr;
  logic        conns;
  logic        pstxid;
  logic        psrxfhs;
  logic        psackfhs;
  logic        connsnewslave;
  logic        page_scan_window;
  logic        ps_pagerespto;
  logic        tx_packet_st_p;
  logic        tx_first_slot;

  // one-shot requests for the next tick
  logic req_enable;
  logic req_cancel;
  logic req_hit;
  logic req_fhs;
  logic req_cmd;
  logic poll_level;

  // strobe dividers
  int us_div;
  int us_idx;

  // reference model state
  lc_state_t m_cs;
  lc_state_t m_ret;
  logic      m_scan_en;
  int        m_slot;
  int        m_us;
  int        m_resp;
  int        m_conn;
  logic      m_pend;
  logic      m_first;

  int interval;
  int win_slots;

  lc_clk_gen clk_gen_i (
    .clk_6M (clk_6M),
    .rstz   (rstz)
  );

  link_ctrl_top link_ctrl_top_i (
    .clk_6M             (clk_6M),
    .rstz               (rstz),
    .p_1us              (p_1us),
    .s_tslot_p          (s_tslot_p),
    .page_scan_enable_p (page_scan_enable_p),
    .page_scan_cancel_p (page_scan_cancel_p),
    .t_ps_interval      (t_ps_interval),
    .t_ps_window        (t_ps_window),
    .corre_hit          (corre_hit),
    .fhs_ok             (fhs_ok),
    .poll_addressed     (poll_addressed),
    .tx_cmd_p           (tx_cmd_p),
    .ps                 (ps),
    .spr                (spr),
    .conns              (conns),
    .pstxid             (pstxid),
    .psrxfhs            (psrxfhs),
    .psackfhs           (psackfhs),
    .connsnewslave      (connsnewslave),
    .page_scan_window   (page_scan_window),
    .ps_pagerespto      (ps_pagerespto),
    .tx_packet_st_p     (tx_packet_st_p),
    .tx_first_slot      (tx_first_slot)
  );

  //////////////////////////////
  // checking helpers
  //////////////////////////////

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("[FAIL] %0t ns: %s is %b, expected %b", $time, name, got, exp);
      $display("Verification failed");
      $fatal(1, "output mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("Verification failed");
    $fatal(1, "wait limit reached");
  endtask

  task automatic reset_model();
    m_cs      = st_standby;
    m_ret     = st_standby;
    m_scan_en = 1'b0;
    m_slot    = 0;
    m_us      = 0;
    m_resp    = 0;
    m_conn    = 0;
    m_pend    = 1'b0;
    m_first   = 1'b0;
  endtask

  //////////////////////////////
  // one clock of stimulus and model
  //////////////////////////////

  task automatic tick();
    logic win;
    logic half_end;
    logic resp_end;
    logic conn_end;
    logic hit;
    logic poll_acc;
    logic conn_tx;
    logic done;
    logic tx;
    @(posedge clk_6M);
    #1;
    // 1us strobe every 6 clocks
    // slot pulse on every 625th strobe
    p_1us     = (us_div == 5);
    s_tslot_p = p_1us && (us_idx == 624);
    if (p_1us)
      us_idx = (us_idx == 624) ? 0 : us_idx + 1;
    us_div = (us_div == 5) ? 0 : us_div + 1;
    page_scan_enable_p = req_enable;
    page_scan_cancel_p = req_cancel;
    corre_hit          = req_hit;
    fhs_ok             = req_fhs;
    tx_cmd_p           = req_cmd;
    poll_addressed     = poll_level;
    req_enable = 1'b0;
    req_cancel = 1'b0;
    req_hit    = 1'b0;
    req_fhs    = 1'b0;
    req_cmd    = 1'b0;
    #4;
    // expected combinational values
    win      = m_scan_en && (m_slot < int'(t_ps_window));
    half_end = (m_cs == st_slave_txid) && p_1us && (m_us == half_slot_us - 1);
    resp_end = (m_cs == st_slave_rxfhs) && s_tslot_p && (m_resp == resp_to_slots - 1);
    conn_end = (m_cs == st_conn_new_slave) && s_tslot_p && (m_conn == conn_to_slots - 1);
    hit      = (m_cs == st_page_scan) && win && corre_hit;
    poll_acc = (m_cs == st_conn_new_slave) && poll_addressed && s_tslot_p;
    conn_tx  = (m_cs == st_conn_active) && s_tslot_p && m_pend;
    done     = (m_cs == st_slave_ackfhs) && s_tslot_p;
    tx = hit || ((m_cs == st_slave_rxfhs_done) && s_tslot_p) || poll_acc || conn_tx;
    check_bit("page_scan_window", page_scan_window, win);
    check_bit("ps", ps, m_cs == st_page_scan);
    check_bit("pstxid", pstxid, m_cs == st_slave_txid);
    check_bit("psrxfhs", psrxfhs, (m_cs == st_slave_rxfhs) || (m_cs == st_slave_rxfhs_done));
    check_bit("psackfhs", psackfhs, m_cs == st_slave_ackfhs);
    check_bit("spr", spr, (m_cs == st_slave_txid) || (m_cs == st_slave_rxfhs) ||
              (m_cs == st_slave_rxfhs_done) || (m_cs == st_slave_ackfhs));
    check_bit("connsnewslave", connsnewslave,
              (m_cs == st_conn_new_slave) || (m_cs == st_conn_ackpoll));
    check_bit("conns", conns, (m_cs == st_conn_new_slave) || (m_cs == st_conn_ackpoll) ||
              (m_cs == st_conn_active));
    check_bit("ps_pagerespto", ps_pagerespto, resp_end);
    check_bit("tx_packet_st_p", tx_packet_st_p, tx);
    check_bit("tx_first_slot", tx_first_slot, m_first);
    if (!rstz)
      reset_model();
    else
    begin
      // interval counter sees the old enable
      if (page_scan_enable_p)
        m_slot = 0;
      else if (m_scan_en && s_tslot_p)
        m_slot = (m_slot == int'(t_ps_interval) - 1) ? 0 : m_slot + 1;
      if (page_scan_cancel_p || done)
        m_scan_en = 1'b0;
      else if (page_scan_enable_p)
        m_scan_en = 1'b1;
      // counters only run in their own state
      m_us   = (m_cs == st_slave_txid) ? m_us + int'(p_1us) : 0;
      m_resp = (m_cs == st_slave_rxfhs) ? m_resp + int'(s_tslot_p) : 0;
      m_conn = (m_cs == st_conn_new_slave) ? m_conn + int'(s_tslot_p) : 0;
      if (tx_cmd_p)
        m_pend = 1'b1;
      else if (conn_tx)
        m_pend = 1'b0;
      if (tx)
        m_first = 1'b1;
      else if (s_tslot_p)
        m_first = 1'b0;
      case (m_cs)
        st_standby, st_conn_active:
          if (win)
          begin
            m_ret = m_cs;
            m_cs  = st_page_scan;
          end
        st_page_scan:
          if (!win)
            m_cs = m_ret;
          else if (corre_hit)
            m_cs = st_slave_txid;
        st_slave_txid:
          if (half_end)
            m_cs = st_slave_rxfhs;
        st_slave_rxfhs:
          if (resp_end)
            m_cs = st_page_scan;
          else if (fhs_ok)
            m_cs = st_slave_rxfhs_done;
        st_slave_rxfhs_done:
          if (s_tslot_p)
            m_cs = st_slave_ackfhs;
        st_slave_ackfhs:
          if (s_tslot_p)
            m_cs = st_conn_new_slave;
        st_conn_new_slave:
          if (poll_acc)
            m_cs = st_conn_ackpoll;
          else if (conn_end)
            m_cs = st_standby;
        st_conn_ackpoll:
          if (s_tslot_p)
            m_cs = st_conn_active;
        default:
          m_cs = st_standby;
      endcase
    end
  endtask

  //////////////////////////////
  // bounded waits
  //////////////////////////////

  function automatic logic read_output(input string name);
    case (name)
      "ps":               return ps;
      "pstxid":           return pstxid;
      "psrxfhs":          return psrxfhs;
      "psackfhs":         return psackfhs;
      "connsnewslave":    return connsnewslave;
      "page_scan_window": return page_scan_window;
      "ps_pagerespto":    return ps_pagerespto;
      "tx_packet_st_p":   return tx_packet_st_p;
      default:            return 1'bx;
    endcase
  endfunction

  task automatic wait_level(input string name, input logic level, input int limit);
    int n;
    n = 0;
    while ((read_output(name) !== level) && (n < limit))
    begin
      tick();
      n++;
    end
    if (read_output(name) !== level)
      report_timeout($sformatf("%s to become %b", name, level));
  endtask

  task automatic run_slots(input int count);
    int seen;
    int n;
    seen = 0;
    n    = 0;
    while ((seen < count) && (n < (count + 1) * slot_cycles))
    begin
      tick();
      n++;
      if (s_tslot_p)
        seen++;
    end
    if (seen < count)
      report_timeout("slot pulses");
  endtask

  task automatic run_cycles(input int count);
    repeat (count) tick();
  endtask

  // sync hit inside an open window then ID, FHS wait and ack
  task automatic page_response(input logic with_fhs);
    run_cycles($urandom % 50);
    req_hit = 1'b1;
    tick();
    wait_level("pstxid", 1'b1, 2);
    wait_level("psrxfhs", 1'b1, (half_slot_us + 2) * 6);
    if (with_fhs)
    begin
      // FHS well before the response timeout
      run_cycles($urandom % ((resp_to_slots - 2) * slot_cycles));
      req_fhs = 1'b1;
      tick();
      wait_level("psackfhs", 1'b1, 2 * slot_cycles);
      wait_level("connsnewslave", 1'b1, 2 * slot_cycles);
    end
    else
      wait_level("ps_pagerespto", 1'b1, (resp_to_slots + 1) * slot_cycles);
  endtask

  task automatic start_scan();
    req_enable = 1'b1;
    tick();
    wait_level("ps", 1'b1, 3);
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial
  begin
    int i;
    int k;
    int n;
    p_1us = 1'b0;
    s_tslot_p = 1'b0;
    page_scan_enable_p = 1'b0;
    page_scan_cancel_p = 1'b0;
    corre_hit = 1'b0;
    fhs_ok = 1'b0;
    poll_addressed = 1'b0;
    tx_cmd_p = 1'b0;
    req_enable = 1'b0;
    req_cancel = 1'b0;
    req_hit = 1'b0;
    req_fhs = 1'b0;
    req_cmd = 1'b0;
    poll_level = 1'b0;
    us_div = 0;
    us_idx = 0;
    reset_model();
    // interval of 4 to 12 slots
    // window of 2 up to the interval minus 1
    interval  = 4 + ($urandom(32'hf7c4d15e) % 9);
    win_slots = 2 + ($urandom % (interval - 2));
    t_ps_interval = slot_count_t'(interval);
    t_ps_window   = slot_count_t'(win_slots);
    n = 0;
    while (!rstz && (n < 10))
    begin
      tick();
      n++;
    end
    if (!rstz)
      report_timeout("reset release");
    // scan windows over several intervals then a cancel
    run_cycles(10 + ($urandom % 100));
    req_enable = 1'b1;
    tick();
    wait_level("page_scan_window", 1'b1, 1);
    wait_level("ps", 1'b1, 1);
    run_slots(2 * interval + 1);
    run_cycles($urandom % slot_cycles);
    // cancel wins over a repeated enable
    req_cancel = 1'b1;
    req_enable = 1'b1;
    tick();
    run_slots(2);
    // response timeout then a fresh window and a good FHS
    start_scan();
    page_response(1'b0);
    wait_level("ps", 1'b1, 2);
    wait_level("ps", 1'b0, (interval + 1) * slot_cycles);
    wait_level("ps", 1'b1, (interval + 1) * slot_cycles);
    page_response(1'b1);
    // no poll so back to standby
    wait_level("connsnewslave", 1'b0, (conn_to_slots + 1) * slot_cycles);
    run_slots(interval + 1);
    // addressed poll before the timeout
    start_scan();
    page_response(1'b1);
    k = $urandom % (conn_to_slots - 2);
    run_slots(k);
    poll_level = 1'b1;
    run_slots(1);
    poll_level = 1'b0;
    wait_level("connsnewslave", 1'b0, 2 * slot_cycles);
    // host commands in the active connection
    for (i = 0; i < 4; i++)
    begin
      run_cycles($urandom % (2 * slot_cycles));
      req_cmd = 1'b1;
      tick();
      if ($urandom % 2)
      begin
        run_cycles(1 + ($urandom % 20));
        req_cmd = 1'b1;
        tick();
      end
      wait_level("tx_packet_st_p", 1'b1, 2 * slot_cycles);
      run_slots(1 + ($urandom % 2));
    end
    // scan interrupts the connection
    // command waits for the return
    start_scan();
    req_cmd = 1'b1;
    tick();
    wait_level("ps", 1'b0, (interval + 1) * slot_cycles);
    wait_level("tx_packet_st_p", 1'b1, 2 * slot_cycles);
    req_cancel = 1'b1;
    tick();
    run_slots(interval + 1);
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+source
source/lc_state_pkg.sv
source/lc_time_pkg.sv
source/lc_timer_if.sv
source/page_scan_window.sv
source/slave_resp_timers.sv
source/lc_fsm.sv
source/link_ctrl_top.sv
test/lc_clk_gen.sv
test/tb_link_ctrl.sv

//--- Bender.yml
package:
  name: link_ctrl

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/lc_state_pkg.sv
      - source/lc_time_pkg.sv
      - source/lc_timer_if.sv
      - source/page_scan_window.sv
      - source/slave_resp_timers.sv
      - source/lc_fsm.sv
      - source/link_ctrl_top.sv
  - target: test
    files:
      - test/lc_clk_gen.sv
      - test/tb_link_ctrl.sv
